/* hdl/dhcp_tx_pkg.sv */
package dhcp_tx_pkg;

  //////////////////////////////
  // types
  //////////////////////////////
  typedef logic [7:0]  byte_t;      // one stream octet
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;  // byte 0 in [47:40]
  typedef logic [31:0] xid_t;
  typedef logic [1:0]  opt_mask_t;  // bit 0 req ip and bit 1 client id
  typedef logic [4:0]  opt_len_t;   // options bytes without end code
  typedef logic [15:0] udp_len_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [1:0] {
    st_idle,
    st_assemble,
    st_send,
    st_done
  } ctrl_state_t;

  //////////////////////////////
  // frame sizes
  //////////////////////////////
  localparam int DHCP_HDR_LEN = 240;  // bootp header plus cookie
  localparam int UDP_HDR_LEN  = 8;
  localparam int OPT_BUF_LEN  = 18;   // all three options packed
  localparam int OPT_NUM      = 3;
  localparam int OPT_REC_LEN  = 9;    // widest record is client id
  localparam int OPT_HDR_LEN  = 2;    // code and len bytes

  // option codes and data lengths
  localparam byte_t OPT_CODE_MSG_TYPE  = 8'd53;
  localparam byte_t OPT_LEN_MSG_TYPE   = 8'd1;
  localparam byte_t OPT_CODE_REQ_IP    = 8'd50;
  localparam byte_t OPT_LEN_REQ_IP     = 8'd4;
  localparam byte_t OPT_CODE_CLIENT_ID = 8'd61;
  localparam byte_t OPT_LEN_CLIENT_ID  = 8'd7;
  localparam byte_t CLIENT_ID_HTYPE    = 8'd1;   // ethernet, ahead of the mac
  localparam byte_t OPT_END            = 8'd255;

  // fixed bootp fields
  localparam byte_t       BOOTP_OP_REQ    = 8'd1;
  localparam byte_t       BOOTP_HTYPE_ETH = 8'd1;
  localparam byte_t       BOOTP_HLEN_ETH  = 8'd6;
  localparam logic [15:0] BOOTP_FLAGS     = 16'h8000;  // broadcast
  localparam logic [31:0] MAGIC_COOKIE    = 32'h63825363;
  localparam int          HDR_XID_OFS     = 4;
  localparam int          HDR_FLAGS_OFS   = 10;
  localparam int          HDR_CHADDR_OFS  = 28;
  localparam int          HDR_COOKIE_OFS  = 236;

  // apb register map
  localparam apb_addr_t REG_CTRL     = 8'h00;
  localparam apb_addr_t REG_XID      = 8'h04;
  localparam apb_addr_t REG_REQ_IP   = 8'h08;
  localparam apb_addr_t REG_MAC_LO   = 8'h0C;  // mac bytes 2..5
  localparam apb_addr_t REG_MAC_HI   = 8'h10;  // mac bytes 0..1
  localparam apb_addr_t REG_MSG_TYPE = 8'h14;
  localparam apb_addr_t REG_STATUS   = 8'h18;

endpackage

/* hdl/dhcp_req_if.sv */
interface dhcp_req_if import dhcp_tx_pkg::*; ();

  // programmed request, stable while busy
  xid_t      xid;
  mac_addr_t mac;
  ip_addr_t  req_ip;
  byte_t     msg_type;   // value of option 53
  opt_mask_t opt_mask;

  logic      start;      // one cycle, from a ctrl write
  logic      busy;       // frame in flight

  modport regs (
    output xid,
    output mac,
    output req_ip,
    output msg_type,
    output opt_mask,
    output start,
    input  busy
  );

  modport ctrl (
    input  start,
    output busy
  );

  modport dp (
    input xid,
    input mac,
    input req_ip,
    input msg_type,
    input opt_mask
  );

endinterface

/* hdl/dhcp_apb_regs.sv */
module dhcp_apb_regs import dhcp_tx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_data_t pwdata,
  input  logic      frame_done,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  dhcp_req_if.regs  req
);

  logic       access;     // apb access phase
  logic       addr_hit;
  logic       wr_bad;
  logic       wr_ok;
  logic [7:0] frame_cnt;  // sent frames, wraps

  assign access = psel & penable;
  assign pready = 1'b1;  // zero wait states

  always_comb begin
    case (paddr)
      REG_CTRL, REG_XID, REG_REQ_IP, REG_MAC_LO,
      REG_MAC_HI, REG_MSG_TYPE, REG_STATUS: addr_hit = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  // status is read only, fields locked while busy
  assign wr_bad  = pwrite & ((paddr == REG_STATUS) | req.busy);
  assign pslverr = access & (~addr_hit | wr_bad);
  assign wr_ok   = access & pwrite & addr_hit & ~wr_bad;

  assign req.start = wr_ok & (paddr == REG_CTRL) & pwdata[0];  // start bit not stored

  //////////////////////////////
  // field registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      req.xid      <= '0;
      req.mac      <= '0;
      req.req_ip   <= '0;
      req.msg_type <= '0;
      req.opt_mask <= '0;
    end else if (wr_ok) begin
      case (paddr)
        REG_CTRL:     req.opt_mask   <= pwdata[2:1];
        REG_XID:      req.xid        <= pwdata;
        REG_REQ_IP:   req.req_ip     <= pwdata;
        REG_MAC_LO:   req.mac[31:0]  <= pwdata;
        REG_MAC_HI:   req.mac[47:32] <= pwdata[15:0];
        REG_MSG_TYPE: req.msg_type   <= pwdata[7:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 8'd1;  // same edge busy drops
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////
  always_comb begin
    prdata = '0;
    if (access & ~pwrite) begin
      case (paddr)
        REG_CTRL:     prdata = {29'd0, req.opt_mask, 1'b0};  // start reads 0
        REG_XID:      prdata = req.xid;
        REG_REQ_IP:   prdata = req.req_ip;
        REG_MAC_LO:   prdata = req.mac[31:0];
        REG_MAC_HI:   prdata = {16'd0, req.mac[47:32]};
        REG_MSG_TYPE: prdata = {24'd0, req.msg_type};
        REG_STATUS:   prdata = {16'd0, frame_cnt, 7'd0, req.busy};
        default:      prdata = '0;
      endcase
    end
  end

endmodule

/* hdl/dhcp_tx_ctrl.sv */
module dhcp_tx_ctrl import dhcp_tx_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     asm_done,
  input  logic     send_done,
  output logic     asm_go,
  output logic     send_go,
  dhcp_req_if.ctrl req
);

  ctrl_state_t state;
  logic        launch;    // start taken this cycle
  logic        frame_end; // last beat accepted

  // st_done lasts one cycle and takes a new start like idle
  assign launch    = req.start & ((state == st_idle) | (state == st_done));
  assign frame_end = (state == st_send) & send_done;

  // comb so tx_val rises the cycle after asm_done
  assign send_go = (state == st_assemble) & asm_done;

  //////////////////////////////
  // state machine
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle, st_done: begin
          if (launch) begin
            state <= st_assemble;
          end else begin
            state <= st_idle;
          end
        end
        st_assemble: begin
          if (asm_done) begin
            state <= st_send;  // options packed
          end
        end
        st_send: begin
          if (send_done) begin
            state <= st_done;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // asm_go one cycle after start, so the mask written with start is in place
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      asm_go <= 1'b0;
    end else begin
      asm_go <= launch;
    end
  end

  // busy rises on start and drops with the eof beat
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      req.busy <= 1'b0;
    end else if (launch) begin
      req.busy <= 1'b1;
    end else if (frame_end) begin
      req.busy <= 1'b0;
    end
  end

endmodule

/* hdl/dhcp_opt_asm.sv */
module dhcp_opt_asm import dhcp_tx_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     asm_go,
  dhcp_req_if.dp   req,
  output logic     asm_done,
  output byte_t    opt_bytes [OPT_BUF_LEN],
  output opt_len_t opt_len
);

  byte_t              proto [OPT_NUM][OPT_REC_LEN];  // records in code order
  logic [OPT_NUM-1:0] pres;       // presence, shifts with proto
  logic [1:0]         shift_cnt;
  logic               shifting;
  opt_len_t           rec_len;    // bytes of head record

  assign rec_len = opt_len_t'(proto[0][1]) + opt_len_t'(OPT_HDR_LEN);

  //////////////////////////////
  // shift control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      shifting  <= 1'b0;
      shift_cnt <= '0;
      pres      <= '0;
      opt_len   <= '0;
      asm_done  <= 1'b0;
    end else begin
      asm_done <= 1'b0;
      if (asm_go) begin
        shifting  <= 1'b1;
        shift_cnt <= '0;
        opt_len   <= '0;
        pres      <= {req.opt_mask[1], req.opt_mask[0], 1'b1};  // msg type always
      end else if (shifting) begin
        shift_cnt <= shift_cnt + 2'd1;
        pres      <= pres >> 1;
        if (pres[0]) begin
          opt_len <= opt_len + rec_len;  // advance fill point
        end
        if (shift_cnt == 2'(OPT_NUM - 1)) begin
          shifting <= 1'b0;
          asm_done <= 1'b1;  // OPT_NUM + 1 cycles after asm_go
        end
      end
    end
  end

  //////////////////////////////
  // record buffer and packing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (asm_go) begin
      proto[0] <= '{OPT_CODE_MSG_TYPE, OPT_LEN_MSG_TYPE, req.msg_type,
                    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
      proto[1] <= '{OPT_CODE_REQ_IP, OPT_LEN_REQ_IP,
                    req.req_ip[31:24], req.req_ip[23:16],
                    req.req_ip[15:8], req.req_ip[7:0],
                    8'h00, 8'h00, 8'h00};
      proto[2] <= '{OPT_CODE_CLIENT_ID, OPT_LEN_CLIENT_ID, CLIENT_ID_HTYPE,
                    req.mac[47:40], req.mac[39:32], req.mac[31:24],
                    req.mac[23:16], req.mac[15:8], req.mac[7:0]};
    end else if (shifting) begin
      for (int k = 0; k < OPT_NUM - 1; k++) begin
        proto[k] <= proto[k + 1];  // next record to head
      end
      if (pres[0]) begin
        // copy head record at the fill point, no gap
        for (int i = 0; i < OPT_REC_LEN; i++) begin
          if ((i < int'(rec_len)) && (int'(opt_len) + i < OPT_BUF_LEN)) begin
            opt_bytes[int'(opt_len) + i] <= proto[0][i];
          end
        end
      end
    end
  end

endmodule

/* hdl/dhcp_frame_ser.sv */
module dhcp_frame_ser import dhcp_tx_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     send_go,
  input  byte_t    opt_bytes [OPT_BUF_LEN],
  input  opt_len_t opt_len,
  dhcp_req_if.dp   req,
  input  logic     tx_rdy,
  output logic     send_done,
  output byte_t    tx_dat,
  output logic     tx_val,
  output logic     tx_sof,
  output logic     tx_eof,
  output udp_len_t udp_len
);

  logic [8:0] idx;       // byte index into the frame
  logic [8:0] last_idx;  // position of the end code
  logic [4:0] opt_idx;
  logic       beat;      // accepted byte
  byte_t      hdr_byte;

  assign last_idx  = 9'(DHCP_HDR_LEN) + 9'(opt_len);
  assign opt_idx   = 5'(idx - 9'(DHCP_HDR_LEN));
  assign beat      = tx_val & tx_rdy;
  assign tx_sof    = tx_val & (idx == 9'd0);
  assign tx_eof    = tx_val & (idx == last_idx);
  assign send_done = beat & tx_eof;

  //////////////////////////////
  // header byte by index
  //////////////////////////////
  always_comb begin
    case (idx)
      9'd0:                  hdr_byte = BOOTP_OP_REQ;
      9'd1:                  hdr_byte = BOOTP_HTYPE_ETH;
      9'd2:                  hdr_byte = BOOTP_HLEN_ETH;
      9'(HDR_XID_OFS):       hdr_byte = req.xid[31:24];  // xid big endian
      9'(HDR_XID_OFS + 1):   hdr_byte = req.xid[23:16];
      9'(HDR_XID_OFS + 2):   hdr_byte = req.xid[15:8];
      9'(HDR_XID_OFS + 3):   hdr_byte = req.xid[7:0];
      9'(HDR_FLAGS_OFS):     hdr_byte = BOOTP_FLAGS[15:8];
      9'(HDR_FLAGS_OFS + 1): hdr_byte = BOOTP_FLAGS[7:0];
      9'(HDR_CHADDR_OFS):     hdr_byte = req.mac[47:40];  // chaddr, padded to 16
      9'(HDR_CHADDR_OFS + 1): hdr_byte = req.mac[39:32];
      9'(HDR_CHADDR_OFS + 2): hdr_byte = req.mac[31:24];
      9'(HDR_CHADDR_OFS + 3): hdr_byte = req.mac[23:16];
      9'(HDR_CHADDR_OFS + 4): hdr_byte = req.mac[15:8];
      9'(HDR_CHADDR_OFS + 5): hdr_byte = req.mac[7:0];
      9'(HDR_COOKIE_OFS):     hdr_byte = MAGIC_COOKIE[31:24];
      9'(HDR_COOKIE_OFS + 1): hdr_byte = MAGIC_COOKIE[23:16];
      9'(HDR_COOKIE_OFS + 2): hdr_byte = MAGIC_COOKIE[15:8];
      9'(HDR_COOKIE_OFS + 3): hdr_byte = MAGIC_COOKIE[7:0];
      default:                hdr_byte = 8'h00;  // hops, secs, addrs, sname, file
    endcase
  end

  always_comb begin
    if (idx < 9'(DHCP_HDR_LEN)) begin
      tx_dat = hdr_byte;
    end else if (idx < last_idx) begin
      tx_dat = opt_bytes[opt_idx];
    end else begin
      tx_dat = OPT_END;
    end
  end

  //////////////////////////////
  // stream control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_val  <= 1'b0;
      idx     <= '0;
      udp_len <= '0;
    end else if (send_go) begin
      tx_val  <= 1'b1;
      idx     <= '0;
      udp_len <= udp_len_t'(DHCP_HDR_LEN + UDP_HDR_LEN + 1) + udp_len_t'(opt_len);
    end else if (beat) begin
      if (tx_eof) begin
        tx_val <= 1'b0;  // end code accepted
      end else begin
        idx <= idx + 9'd1;  // stall holds idx
      end
    end
  end

endmodule

/* hdl/dhcp_tx_top.sv */
module dhcp_tx_top import dhcp_tx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output byte_t     tx_dat,
  output logic      tx_val,
  output logic      tx_sof,
  output logic      tx_eof,
  input  logic      tx_rdy,
  output udp_len_t  udp_len
);

  logic     asm_go;
  logic     asm_done;
  logic     send_go;
  logic     send_done;  // also counts the frame
  byte_t    opt_bytes [OPT_BUF_LEN];
  opt_len_t opt_len;

  dhcp_req_if u_req ();

  dhcp_apb_regs u_regs (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .frame_done (send_done),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .req        (u_req.regs)
  );

  dhcp_tx_ctrl u_ctrl (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .asm_done  (asm_done),
    .send_done (send_done),
    .asm_go    (asm_go),
    .send_go   (send_go),
    .req       (u_req.ctrl)
  );

  dhcp_opt_asm u_opt_asm (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .asm_go    (asm_go),
    .req       (u_req.dp),
    .asm_done  (asm_done),
    .opt_bytes (opt_bytes),
    .opt_len   (opt_len)
  );

  dhcp_frame_ser u_frame_ser (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .send_go   (send_go),
    .opt_bytes (opt_bytes),
    .opt_len   (opt_len),
    .req       (u_req.dp),
    .tx_rdy    (tx_rdy),
    .send_done (send_done),
    .tx_dat    (tx_dat),
    .tx_val    (tx_val),
    .tx_sof    (tx_sof),
    .tx_eof    (tx_eof),
    .udp_len   (udp_len)
  );

endmodule

/* verification/dhcp_tx_properties.sv */
module dhcp_tx_properties import dhcp_tx_pkg::*; (
  input logic  clk,
  input logic  fsm_rst,
  input byte_t tx_dat,
  input logic  tx_val,
  input logic  tx_sof,
  input logic  tx_eof,
  input logic  tx_rdy,
  input logic  pready
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  sof_in_frame: assert property (@(posedge clk) disable iff (fsm_rst) tx_sof |-> tx_val)
    else begin fail_cnt++; $error("tx_sof high without tx_val"); end

  eof_in_frame: assert property (@(posedge clk) disable iff (fsm_rst) tx_eof |-> tx_val)
    else begin fail_cnt++; $error("tx_eof high without tx_val"); end

  // stalled beat keeps byte and flags
  hold_on_stall: assert property (@(posedge clk) disable iff (fsm_rst)
    (tx_val && !tx_rdy) |=> (tx_val && $stable(tx_dat) && $stable(tx_sof) && $stable(tx_eof)))
    else begin fail_cnt++; $error("stream changed while stalled"); end

  pready_high: assert property (@(posedge clk) disable iff (fsm_rst) pready)
    else begin fail_cnt++; $error("pready low"); end

endmodule

/* verification/dhcp_tx_tb.sv */
module dhcp_tx_tb import dhcp_tx_pkg::*; ();

  logic      clk = 1'b0;
  logic      fsm_rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  byte_t     tx_dat;
  logic      tx_val;
  logic      tx_sof;
  logic      tx_eof;
  logic      tx_rdy;
  udp_len_t  udp_len;

  logic [15:0] lfsr = 16'd95;  // seed
  byte_t       exp_bytes [$];  // model frame
  udp_len_t    exp_udp;
  xid_t        cur_xid;        // last programmed fields
  mac_addr_t   cur_mac;
  ip_addr_t    cur_ip;
  byte_t       cur_msg;
  opt_mask_t   cur_mask;
  int          errors = 0;
  int          err_mark = 0;   // errors before current test
  int          n_checks = 0;
  int          n_tests = 0;
  int          frames_done = 0;

  always #20 clk = ~clk;  // period 40

  dhcp_tx_top u_dut (.*);

  bind dhcp_tx_top dhcp_tx_properties u_props (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .tx_dat  (tx_dat),
    .tx_val  (tx_val),
    .tx_sof  (tx_sof),
    .tx_eof  (tx_eof),
    .tx_rdy  (tx_rdy),
    .pready  (pready)
  );

  //////////////////////////////
  // random numbers
  //////////////////////////////
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16 + x^14 + x^13 + x^11
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[30:0], rand_bit()};  // one step per bit
    end
    return w;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic void build_frame(input xid_t xid, input mac_addr_t mac,
                                      input ip_addr_t ip, input byte_t msg,
                                      input opt_mask_t mask);
    int olen;
    exp_bytes.delete();
    exp_bytes.push_back(8'd1);  // op
    exp_bytes.push_back(8'd1);  // htype
    exp_bytes.push_back(8'd6);  // hlen
    exp_bytes.push_back(8'd0);  // hops
    for (int i = 3; i >= 0; i--) begin
      exp_bytes.push_back(xid[8*i +: 8]);  // msb first
    end
    exp_bytes.push_back(8'h00);  // secs
    exp_bytes.push_back(8'h00);
    exp_bytes.push_back(8'h80);  // broadcast flag
    exp_bytes.push_back(8'h00);
    repeat (16) exp_bytes.push_back(8'h00);  // ciaddr to giaddr
    for (int i = 5; i >= 0; i--) begin
      exp_bytes.push_back(mac[8*i +: 8]);
    end
    repeat (10 + 192) exp_bytes.push_back(8'h00);  // chaddr pad, sname, file
    exp_bytes.push_back(8'h63);  // cookie
    exp_bytes.push_back(8'h82);
    exp_bytes.push_back(8'h53);
    exp_bytes.push_back(8'h63);
    exp_bytes.push_back(8'd53);  // msg type always sent
    exp_bytes.push_back(8'd1);
    exp_bytes.push_back(msg);
    olen = 3;
    if (mask[0]) begin
      exp_bytes.push_back(8'd50);  // requested ip
      exp_bytes.push_back(8'd4);
      for (int i = 3; i >= 0; i--) begin
        exp_bytes.push_back(ip[8*i +: 8]);
      end
      olen += 6;
    end
    if (mask[1]) begin
      exp_bytes.push_back(8'd61);  // client id
      exp_bytes.push_back(8'd7);
      exp_bytes.push_back(8'd1);   // htype ahead of mac
      for (int i = 5; i >= 0; i--) begin
        exp_bytes.push_back(mac[8*i +: 8]);
      end
      olen += 9;
    end
    exp_bytes.push_back(8'd255);  // end option
    exp_udp = udp_len_t'(240 + 8 + olen + 1);
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input udp_len_t got, input udp_len_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_apb(input string name, input apb_data_t got, input apb_data_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // apb bus
  //////////////////////////////
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;  // setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;  // access phase
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;  // comb in access phase
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_ok(input apb_addr_t addr, input apb_data_t data);
    logic err;
    apb_write(addr, data, err);
    check_apb("pslverr", apb_data_t'(err), 32'h0);
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_read(addr, rd, err);
    check_apb($sformatf("prdata@0x%h", addr), rd, exp);
    check_apb("pslverr", apb_data_t'(err), 32'h0);
  endtask

  //////////////////////////////
  // frame helpers
  //////////////////////////////
  task automatic program_request(input opt_mask_t mask);
    logic [31:0] hi;
    cur_xid  = rand_word(32);
    hi       = rand_word(16);
    cur_mac  = {hi[15:0], rand_word(32)};
    cur_ip   = rand_word(32);
    hi       = rand_word(8);
    cur_msg  = hi[7:0];
    cur_mask = mask;
    write_ok(REG_XID, cur_xid);
    write_ok(REG_REQ_IP, cur_ip);
    write_ok(REG_MAC_LO, cur_mac[31:0]);
    write_ok(REG_MAC_HI, {16'd0, cur_mac[47:32]});
    write_ok(REG_MSG_TYPE, {24'd0, cur_msg});
    build_frame(cur_xid, cur_mac, cur_ip, cur_msg, cur_mask);
  endtask

  task automatic start_frame();
    write_ok(REG_CTRL, {29'd0, cur_mask, 1'b1});  // mask and start together
  endtask

  task automatic collect_frame(input logic stall);
    int   n;
    int   last;
    logic done;
    n    = 0;
    done = 1'b0;
    last = exp_bytes.size() - 1;
    while (!done) begin
      @(posedge clk);
      if (stall) begin
        tx_rdy <= rand_bit();  // about half the cycles stalled
      end else begin
        tx_rdy <= 1'b1;
      end
      @(negedge clk);
      if (tx_val) begin
        if (n > last) begin
          errors++;
          $display("stream runs past the %0d bytes of the model", last + 1);
          done = 1'b1;
        end else begin
          check_byte($sformatf("tx_dat[%0d]", n), tx_dat, exp_bytes[n]);  // also while held
          check_byte("tx_sof", byte_t'(tx_sof), byte_t'(n == 0));
          check_byte("tx_eof", byte_t'(tx_eof), byte_t'(n == last));
          check_len("udp_len", udp_len, exp_udp);
          if (tx_rdy) begin
            n++;          // beat taken on next edge
            done = tx_eof;
          end
        end
      end
    end
    if (n != last + 1) begin
      errors++;
      $display("frame ended after %0d bytes, model has %0d", n, last + 1);
    end
    @(negedge clk);
    check_byte("tx_val", byte_t'(tx_val), 8'h00);  // stream idle after the end code
    frames_done++;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (errors == err_mark) begin
      $display("test %0d %s ok", n_tests, name);
    end else begin
      $display("test %0d %s failed with %0d errors", n_tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic test_regs();
    read_expect(REG_STATUS, 32'h0);  // idle with no frames
    program_request(2'b00);
    read_expect(REG_XID, cur_xid);
    read_expect(REG_REQ_IP, cur_ip);
    read_expect(REG_MAC_LO, cur_mac[31:0]);
    read_expect(REG_MAC_HI, {16'd0, cur_mac[47:32]});
    read_expect(REG_MSG_TYPE, {24'd0, cur_msg});
    end_test("register readback");
  endtask

  task automatic test_frames(input string name, input int count, input logic stall,
                             input logic all_opts);
    logic [31:0] m;
    for (int i = 0; i < count; i++) begin
      m = all_opts ? 32'd3 : rand_word(2);
      program_request(m[1:0]);
      start_frame();
      collect_frame(stall);
    end
    end_test(name);
  endtask

  task automatic test_errors();
    apb_data_t   rd;
    logic        err;
    logic [31:0] m;
    apb_write(8'h1C, 32'h1, err);  // unmapped
    check_apb("pslverr", apb_data_t'(err), 32'h1);
    apb_write(REG_STATUS, 32'h1, err);  // read only
    check_apb("pslverr", apb_data_t'(err), 32'h1);
    apb_read(8'h40, rd, err);
    check_apb("pslverr", apb_data_t'(err), 32'h1);
    m = rand_word(2);
    program_request(m[1:0]);
    start_frame();
    fork
      collect_frame(1'b0);
      begin
        apb_write(REG_XID, ~cur_xid, err);  // field write while busy
        check_apb("pslverr", apb_data_t'(err), 32'h1);
        apb_write(REG_CTRL, {29'd0, ~cur_mask, 1'b1}, err);  // restart with other mask
        check_apb("pslverr", apb_data_t'(err), 32'h1);
        apb_write(REG_MAC_LO, ~cur_mac[31:0], err);
        check_apb("pslverr", apb_data_t'(err), 32'h1);
      end
    join
    read_expect(REG_XID, cur_xid);
    read_expect(REG_CTRL, {29'd0, cur_mask, 1'b0});
    end_test("error handling");
  endtask

  task automatic test_status();
    logic [31:0] m;
    m = rand_word(2);
    program_request(m[1:0]);
    start_frame();
    fork
      collect_frame(1'b1);
      begin
        while (!tx_val) begin
          @(negedge clk);  // frame under way
        end
        read_expect(REG_STATUS, apb_data_t'((frames_done % 256) * 256 + 1));
      end
    join
    read_expect(REG_STATUS, apb_data_t'((frames_done % 256) * 256));
    end_test("status");
  endtask

  //////////////////////////////
  // run
  //////////////////////////////
  initial begin
    int wd_cycles;
    wd_cycles = 10 * (259 * 4 + 60) + 500;  // 10 frames, 4x stall, apb and assembly
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, a frame or handshake never finished",
             wd_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    int total;
    fsm_rst = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    tx_rdy  = 1'b1;
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;
    test_regs();
    test_frames("all options", 1, 1'b0, 1'b1);
    test_frames("random masks", 4, 1'b0, 1'b0);
    test_frames("back-pressure", 3, 1'b1, 1'b0);
    test_errors();
    test_status();
    total = errors + int'(u_dut.u_props.fail_cnt);  // checks plus assertions
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, n_checks, errors, u_dut.u_props.fail_cnt);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/dhcp_tx_pkg.sv
hdl/dhcp_req_if.sv
hdl/dhcp_apb_regs.sv
hdl/dhcp_tx_ctrl.sv
hdl/dhcp_opt_asm.sv
hdl/dhcp_frame_ser.sv
hdl/dhcp_tx_top.sv
verification/dhcp_tx_properties.sv
verification/dhcp_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dhcp_tx_tb
RTL_TOP   ?= dhcp_tx_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUNARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
